//--- include/npc_defs.svh
`ifndef NPC_DEFS_SVH
`define NPC_DEFS_SVH

// ----------------------------------------------------------------------
// core datapath
// ----------------------------------------------------------------------
`define NPC_DATA_W      32
`define NPC_ADDR_W      32
`define NPC_RESET_PC    32'h0000_0000

// ----------------------------------------------------------------------
// instruction memory
// ----------------------------------------------------------------------
`define ROM_DEPTH       16
`define ROM_AR_WAIT     2
// must be at least 1.
`define ROM_R_WAIT      3

// ----------------------------------------------------------------------
// axi read attributes
// ----------------------------------------------------------------------
`define AXI_ID_W        4
`define IFU_AXI_ID      4'h1
`define AXI_SIZE_WORD   3'b010
`define AXI_BURST_INCR  2'b01
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

//--- hw/npc_pkg.sv
`include "npc_defs.svh"

package npc_pkg;

  typedef logic [`NPC_ADDR_W-1:0] addr_t;
  typedef logic [`NPC_DATA_W-1:0] word_t;
  typedef logic [`AXI_ID_W-1:0]   axi_id_t;
  typedef logic [1:0]             axi_resp_t;

  // ar channel, master to slave.
  typedef struct packed {
    logic       valid;
    addr_t      addr;
    axi_id_t    id;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } ar_req_t;

  // r channel, slave to master.
  typedef struct packed {
    logic      valid;
    word_t     data;
    axi_resp_t resp;
    logic      last;
    axi_id_t   id;
  } r_resp_t;

  // result handed to the next stage.
  typedef struct packed {
    addr_t pc;
    word_t inst;
    logic  err;
  } fetch_t;

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA,
    HOLD
  } ifu_state_e;

endpackage

//--- hw/ifu_pc_reg.sv
`include "npc_defs.svh"

module ifu_pc_reg (
  input  logic             clock,
  input  logic             rst_n_i,
  input  logic             pc_we_i,
  input  logic             res_we_i,
  input  logic             branch_en_i,
  input  npc_pkg::addr_t   dnpc_i,
  input  npc_pkg::r_resp_t r_i,
  output npc_pkg::addr_t   pc_o,
  output npc_pkg::fetch_t  fetch_o
);

  npc_pkg::addr_t  pc_q;
  npc_pkg::addr_t  snpc_q;
  npc_pkg::addr_t  next_pc;
  npc_pkg::fetch_t fetch_q;

  // branch target wins over the sequential address.
  assign next_pc = branch_en_i ? dnpc_i : snpc_q;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q   <= `NPC_RESET_PC;
      snpc_q <= `NPC_RESET_PC;
    end else if (pc_we_i) begin
      pc_q   <= next_pc;
      snpc_q <= next_pc + npc_pkg::addr_t'(4);
    end
  end

  // ----------------------------------------------------------------------
  // fetch result
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (res_we_i) begin
      fetch_q.pc   <= pc_q;
      fetch_q.inst <= r_i.data;
      fetch_q.err  <= (r_i.resp != `AXI_RESP_OKAY);
    end
  end

  assign pc_o    = pc_q;
  assign fetch_o = fetch_q;

endmodule

//--- hw/ifu_fsm.sv
module ifu_fsm (
  input  logic clock,
  input  logic rst_n_i,
  input  logic valid_pre_i,
  output logic ready_pre_o,
  output logic valid_post_o,
  input  logic ready_post_i,
  input  logic arready_i,
  output logic arvalid_o,
  input  logic rvalid_i,
  input  logic rlast_i,
  output logic rready_o,
  output logic pc_we_o,
  output logic res_we_o
);

  npc_pkg::ifu_state_e state_q;
  npc_pkg::ifu_state_e state_d;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= npc_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      npc_pkg::IDLE: begin
        if (valid_pre_i) begin
          state_d = npc_pkg::ADDR;
        end
      end
      npc_pkg::ADDR: begin
        if (arready_i) begin
          state_d = npc_pkg::DATA;
        end
      end
      npc_pkg::DATA: begin
        // single beat, but wait for last anyway.
        if (rvalid_i && rlast_i) begin
          state_d = npc_pkg::HOLD;
        end
      end
      npc_pkg::HOLD: begin
        if (ready_post_i) begin
          state_d = npc_pkg::IDLE;
        end
      end
      default: begin
        state_d = npc_pkg::IDLE;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------
  assign ready_pre_o  = (state_q == npc_pkg::IDLE);
  assign arvalid_o    = (state_q == npc_pkg::ADDR);
  assign rready_o     = (state_q == npc_pkg::DATA);
  assign valid_post_o = (state_q == npc_pkg::HOLD);

  assign pc_we_o  = ready_pre_o && valid_pre_i;
  assign res_we_o = rready_o && rvalid_i && rlast_i;

endmodule

//--- hw/ifu.sv
`include "npc_defs.svh"

module ifu (
  input  logic              clock,
  input  logic              rst_n_i,
  input  logic              valid_pre_i,
  output logic              ready_pre_o,
  output logic              valid_post_o,
  input  logic              ready_post_i,
  input  logic              branch_en_i,
  input  npc_pkg::addr_t    dnpc_i,
  output npc_pkg::fetch_t   fetch_o,
  output npc_pkg::ar_req_t  ar_o,
  input  logic              arready_i,
  input  npc_pkg::r_resp_t  r_i,
  output logic              rready_o
);

  logic           pc_we;
  logic           res_we;
  logic           arvalid;
  npc_pkg::addr_t pc;

  ifu_pc_reg u_ifu_pc_reg (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .pc_we_i     (pc_we),
    .res_we_i    (res_we),
    .branch_en_i (branch_en_i),
    .dnpc_i      (dnpc_i),
    .r_i         (r_i),
    .pc_o        (pc),
    .fetch_o     (fetch_o)
  );

  ifu_fsm u_ifu_fsm (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .valid_pre_i  (valid_pre_i),
    .ready_pre_o  (ready_pre_o),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .arready_i    (arready_i),
    .arvalid_o    (arvalid),
    .rvalid_i     (r_i.valid),
    .rlast_i      (r_i.last),
    .rready_o     (rready_o),
    .pc_we_o      (pc_we),
    .res_we_o     (res_we)
  );

  // one word per read, incrementing.
  always_comb begin
    ar_o.valid = arvalid;
    ar_o.addr  = pc;
    ar_o.id    = `IFU_AXI_ID;
    ar_o.len   = 8'd0;
    ar_o.size  = `AXI_SIZE_WORD;
    ar_o.burst = `AXI_BURST_INCR;
  end

endmodule

//--- hw/inst_rom.sv
`include "npc_defs.svh"

module inst_rom (
  input  logic             clock,
  input  logic             rst_n_i,
  input  npc_pkg::ar_req_t ar_i,
  output logic             arready_o,
  output npc_pkg::r_resp_t r_o,
  input  logic             rready_i
);

  npc_pkg::word_t mem [`ROM_DEPTH];

  logic [$clog2(`ROM_DEPTH)-1:0] idx;
  logic                          in_range;
  logic                          ar_hs;
  logic                          r_hs;
  logic [3:0]                    ar_cnt_q;
  logic [3:0]                    r_cnt_q;
  logic                          r_busy_q;
  npc_pkg::word_t                r_data_q;
  npc_pkg::axi_resp_t            r_resp_q;
  npc_pkg::axi_id_t              r_id_q;

  initial begin
    $readmemh("inst.hex", mem);
  end

  assign idx      = ar_i.addr[$clog2(`ROM_DEPTH)+1:2];
  assign in_range = (ar_i.addr >> 2) < `ROM_DEPTH;

  // ----------------------------------------------------------------------
  // address phase
  // ----------------------------------------------------------------------
  // no new address while a response is still pending.
  assign arready_o = ar_i.valid && !r_busy_q && (ar_cnt_q == 4'(`ROM_AR_WAIT));
  assign ar_hs     = ar_i.valid && arready_o;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ar_cnt_q <= '0;
    end else if (ar_hs) begin
      ar_cnt_q <= '0;
    end else if (ar_i.valid && ar_cnt_q != 4'(`ROM_AR_WAIT)) begin
      ar_cnt_q <= ar_cnt_q + 4'd1;
    end
  end

  // ----------------------------------------------------------------------
  // data phase
  // ----------------------------------------------------------------------
  assign r_hs = r_o.valid && rready_i;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_busy_q <= 1'b0;
      r_cnt_q  <= '0;
    end else if (ar_hs) begin
      r_busy_q <= 1'b1;
      r_cnt_q  <= 4'd1;
    end else if (r_hs) begin
      r_busy_q <= 1'b0;
      r_cnt_q  <= '0;
    end else if (r_busy_q && r_cnt_q != 4'(`ROM_R_WAIT)) begin
      r_cnt_q <= r_cnt_q + 4'd1;
    end
  end

  // out of range reads return zero.
  always_ff @(posedge clock) begin
    if (ar_hs) begin
      r_id_q <= ar_i.id;
      if (in_range) begin
        r_data_q <= mem[idx];
        r_resp_q <= `AXI_RESP_OKAY;
      end else begin
        r_data_q <= '0;
        r_resp_q <= `AXI_RESP_SLVERR;
      end
    end
  end

  always_comb begin
    r_o.valid = r_busy_q && (r_cnt_q == 4'(`ROM_R_WAIT));
    r_o.data  = r_data_q;
    r_o.resp  = r_resp_q;
    r_o.last  = 1'b1;
    r_o.id    = r_id_q;
  end

endmodule

//--- hw/ifu_subsys.sv
module ifu_subsys (
  input  logic            clock,
  input  logic            rst_n_i,
  input  logic            valid_pre_i,
  output logic            ready_pre_o,
  output logic            valid_post_o,
  input  logic            ready_post_i,
  input  logic            branch_en_i,
  input  npc_pkg::addr_t  dnpc_i,
  output npc_pkg::fetch_t fetch_o
);

  npc_pkg::ar_req_t ar;
  npc_pkg::r_resp_t r;
  logic             arready;
  logic             rready;

  ifu u_ifu (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .valid_pre_i  (valid_pre_i),
    .ready_pre_o  (ready_pre_o),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .branch_en_i  (branch_en_i),
    .dnpc_i       (dnpc_i),
    .fetch_o      (fetch_o),
    .ar_o         (ar),
    .arready_i    (arready),
    .r_i          (r),
    .rready_o     (rready)
  );

  inst_rom u_inst_rom (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .ar_i      (ar),
    .arready_o (arready),
    .r_o       (r),
    .rready_i  (rready)
  );

endmodule

//--- bench/ifu_props.sv
module ifu_props (
  input logic             clock,
  input logic             rst_n_i,
  input logic             ready_pre_i,
  input logic             valid_post_i,
  input logic             ready_post_i,
  input npc_pkg::fetch_t  fetch_i,
  input npc_pkg::ar_req_t ar_i,
  input logic             arready_i,
  input npc_pkg::r_resp_t r_i,
  input logic             rready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // set between the address transfer and the data transfer.
  logic             ar_done_q;
  // id of the last accepted address.
  npc_pkg::axi_id_t ar_id_q;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ar_done_q <= 1'b0;
      ar_id_q   <= '0;
    end else if (ar_i.valid && arready_i) begin
      ar_done_q <= 1'b1;
      ar_id_q   <= ar_i.id;
    end else if (r_i.valid && rready_i) begin
      ar_done_q <= 1'b0;
    end
  end

  ar_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
    ar_i.valid && !arready_i |=> ar_i.valid && $stable(ar_i.addr))
    else $error("arvalid or araddr changed before arready");

  post_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
    valid_post_i && !ready_post_i |=> valid_post_i && $stable(fetch_i))
    else $error("fetch result changed before it was consumed");

  pre_post_excl: assert property (@(posedge clock) disable iff (!rst_n_i)
    !(ready_pre_i && valid_post_i))
    else $error("ready_pre_o and valid_post_o high together");

  rready_window: assert property (@(posedge clock) disable iff (!rst_n_i)
    rready_i |-> ar_done_q)
    else $error("rready high outside the data phase");

  r_id_echo: assert property (@(posedge clock) disable iff (!rst_n_i)
    r_i.valid |-> r_i.last && (r_i.id == ar_id_q))
    else $error("read data without last or with an id not matching the address");

endmodule

bind ifu ifu_props u_ifu_props (
  .clock        (clock),
  .rst_n_i      (rst_n_i),
  .ready_pre_i  (ready_pre_o),
  .valid_post_i (valid_post_o),
  .ready_post_i (ready_post_i),
  .fetch_i      (fetch_o),
  .ar_i         (ar_o),
  .arready_i    (arready_i),
  .r_i          (r_i),
  .rready_i     (rready_o)
);

//--- bench/tb_ifu_subsys.sv
`include "npc_defs.svh"

module tb_ifu_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int         NROWS   = 14;
  localparam int         MAX_GAP = 7;
  localparam int         MAX_BP  = 7;
  localparam logic [7:0] RND     = 8'hff;

  typedef struct packed {
    logic           br;
    npc_pkg::addr_t target;
    logic [7:0]     gap;
    logic [7:0]     bp;
  } row_t;

  logic            clock, rst_n_i, valid_pre_i, ready_pre_o;
  logic            valid_post_o, ready_post_i, branch_en_i;
  npc_pkg::addr_t  dnpc_i;
  npc_pkg::fetch_t fetch_o;

  row_t           rows [NROWS];
  npc_pkg::word_t image [`ROM_DEPTH];
  logic [31:0]    lfsr;
  npc_pkg::addr_t model_snpc;
  int             checks, mismatches, proto_errs;

  ifu_subsys ifu_subsys_i (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .valid_pre_i  (valid_pre_i),
    .ready_pre_o  (ready_pre_o),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .branch_en_i  (branch_en_i),
    .dnpc_i       (dnpc_i),
    .fetch_o      (fetch_o)
  );

  always #5 clock = ~clock;

  // galois form, taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[6:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic npc_pkg::fetch_t expected_fetch(input npc_pkg::addr_t pc);
    npc_pkg::fetch_t f;
    f.pc  = pc;
    f.err = !((pc >> 2) < `ROM_DEPTH);
    f.inst = f.err ? '0 : image[pc >> 2];
    return f;
  endfunction

  task automatic compare_value(input string name, input logic [64:0] got, input logic [64:0] exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      proto_errs++;
      $display("Error: %s at %0t", what, $time);
    end
  endtask

  task automatic run_row(input row_t r);
    logic [7:0]      gap;
    logic [7:0]      bp;
    npc_pkg::addr_t  pc;
    npc_pkg::fetch_t exp;
    npc_pkg::fetch_t held;
    gap = r.gap;
    bp  = r.bp;
    if (gap == RND) random_bits(3, gap);
    if (bp == RND) random_bits(3, bp);
    pc         = r.br ? r.target : model_snpc;
    model_snpc = pc + 32'd4;
    exp        = expected_fetch(pc);
    repeat (gap) begin
      @(posedge clock);
      @(negedge clock);
      expect_true(ready_pre_o && !valid_post_o, "fetch unit busy during an idle gap");
    end
    @(posedge clock);
    valid_pre_i <= 1'b1;
    branch_en_i <= r.br;
    dnpc_i      <= r.target;
    @(negedge clock);
    while (!ready_pre_o) @(negedge clock);
    @(posedge clock);
    valid_pre_i <= 1'b0;
    branch_en_i <= 1'b0;
    dnpc_i      <= '0;
    @(negedge clock);
    while (!valid_post_o) @(negedge clock);
    held = fetch_o;
    repeat (bp) begin
      @(posedge clock);
      @(negedge clock);
      expect_true(valid_post_o, "valid_post_o dropped under back-pressure");
      expect_true(!ready_pre_o, "new request accepted under back-pressure");
      compare_value("fetch_o (held)", fetch_o, held);
    end
    @(posedge clock);
    ready_post_i <= 1'b1;
    @(negedge clock);
    expect_true(valid_post_o, "valid_post_o low in the consuming cycle");
    compare_value("fetch_o.pc", fetch_o.pc, exp.pc);
    compare_value("fetch_o.inst", fetch_o.inst, exp.inst);
    compare_value("fetch_o.err", fetch_o.err, exp.err);
    @(posedge clock);
    ready_post_i <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // stimulus and sequencing
  // ----------------------------------------------------------------------
  initial begin
    clock        = 1'b0;
    rst_n_i      = 1'b0;
    valid_pre_i  = 1'b0;
    ready_post_i = 1'b0;
    branch_en_i  = 1'b0;
    dnpc_i       = '0;
    lfsr         = 32'h0e61f8ee;
    model_snpc   = `NPC_RESET_PC;
    checks       = 0;
    mismatches   = 0;
    proto_errs   = 0;
    $readmemh("inst.hex", image);
    // branch, target, gap, back-pressure.
    rows[0]  = {1'b0, 32'h0000_0000, 8'd0, 8'd0};
    rows[1]  = {1'b0, 32'h0000_0000, 8'd1, 8'd0};
    rows[2]  = {1'b0, 32'h0000_0000, 8'd0, 8'd3};
    rows[3]  = {1'b0, 32'h0000_0000, RND, RND};
    rows[4]  = {1'b1, 32'h0000_0020, 8'd2, 8'd0};
    rows[5]  = {1'b0, 32'h0000_0000, RND, 8'd1};
    rows[6]  = {1'b0, 32'h0000_0000, 8'd0, RND};
    rows[7]  = {1'b1, 32'h0000_0040, 8'd0, 8'd2};
    rows[8]  = {1'b0, 32'h0000_0000, RND, 8'd0};
    rows[9]  = {1'b1, 32'h0000_003c, 8'd1, 8'd0};
    rows[10] = {1'b0, 32'h0000_0000, 8'd0, RND};
    rows[11] = {1'b1, 32'h0000_0004, RND, RND};
    rows[12] = {1'b0, 32'h0000_0000, 8'd0, 8'd5};
    rows[13] = {1'b1, 32'h0000_1000, RND, 8'd0};
    @(negedge clock);
    expect_true(ready_pre_o && !valid_post_o, "wrong stage handshake in reset");
    expect_true(!ifu_subsys_i.u_ifu.ar_o.valid, "arvalid high in reset");
    expect_true(!ifu_subsys_i.u_ifu.rready_o, "rready high in reset");
    expect_true(!ifu_subsys_i.u_inst_rom.r_o.valid, "rvalid high in reset");
    repeat (3) @(posedge clock);
    rst_n_i <= 1'b1;
    for (int i = 0; i < NROWS; i++) begin
      run_row(rows[i]);
    end
    $display("checks %0d, mismatches %0d, protocol errors %0d", checks, mismatches, proto_errs);
    if (mismatches == 0 && proto_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // slack of 10 cycles for reset.
  initial begin
    repeat (NROWS * (40 + MAX_GAP + MAX_BP) + 10) @(posedge clock);
    $display("Error: watchdog expired before all fetches completed");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- inst.hex
// one 32-bit instruction word per line, word index 0 first.
// word n holds addi x(n+1), x0, n+1.
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813

//--- sources.f
+incdir+include
hw/npc_pkg.sv
hw/ifu_pc_reg.sv
hw/ifu_fsm.sv
hw/ifu.sv
hw/inst_rom.sv
hw/ifu_subsys.sv
bench/ifu_props.sv
bench/tb_ifu_subsys.sv

//--- Bender.yml
package:
  name: ifu_subsys

sources:
  - include_dirs:
      - include
    files:
      - hw/npc_pkg.sv
      - hw/ifu_pc_reg.sv
      - hw/ifu_fsm.sv
      - hw/ifu.sv
      - hw/inst_rom.sv
      - hw/ifu_subsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/ifu_props.sv
      - bench/tb_ifu_subsys.sv
